// ==== source/fetch_pkg.sv ====
package fetch_pkg;

	localparam int xlen = 32; // address and instruction width.
	localparam int line_words = 8; // words in one cache line.
	localparam int offset_bits = 3; // selects a word inside a line.
	localparam int byte_bits = 2; // selects a byte inside a word.
	localparam int index_bits = 4; // default line select width, matches 16 lines.
	localparam int tag_bits = xlen - index_bits - offset_bits - byte_bits;

	// address as the cache sees it.
	typedef struct packed {
		logic [tag_bits-1:0] tag; // compared against the tag array.
		logic [index_bits-1:0] index; // picks the line.
		logic [offset_bits-1:0] offset; // picks the word in the line.
		logic [byte_bits-1:0] byte_sel; // always zero for instruction fetch.
	} fetch_addr_t;

	// request from the pc stage to the cache.
	typedef struct packed {
		logic [xlen-1:0] pc; // fetch address.
		logic cacheable; // set when pc is inside the cacheable window.
	} fetch_req_t;

	// one read beat handed from the bus master to the cache.
	typedef struct packed {
		logic [xlen-1:0] data; // the word read from memory.
		logic [offset_bits-1:0] offset; // word position inside the line.
		logic last; // final beat of the transfer.
		logic cacheable; // beat belongs to a line fill.
	} refill_beat_t;

	// word handed to decode.
	typedef struct packed {
		logic [xlen-1:0] pc; // address the word came from.
		logic [xlen-1:0] inst; // the instruction itself.
	} fetch_out_t;

endpackage

// ==== source/fetch_pc.sv ====
module fetch_pc import fetch_pkg::*; #(
	parameter logic [31:0] reset_pc = 32'h3000_0000,
	parameter logic [31:0] cache_base = 32'ha000_0000,
	parameter logic [31:0] cache_limit = 32'ha200_0000
) (
	input logic clock,
	input logic rst,
	input logic done,
	input logic out_free,
	input logic jump_wrong,
	input logic [31:0] jump_addr,
	output fetch_req_t req,
	output logic req_valid,
	output logic drop
);

	logic [xlen-1:0] pc; // address of the current or next fetch.
	logic busy; // a request has been taken by the cache and is not done yet.
	logic pending; // a redirect came in while a fetch was outstanding.
	logic [xlen-1:0] pending_addr; // target of the pending redirect.
	logic redirect_now; // the fetch finishing this cycle must be thrown away.
	logic [xlen-1:0] target; // where to restart after a dropped fetch.

	// a new request only goes out when the output register can take its word.
	assign req_valid = busy | out_free;
	assign req.pc = pc;
	assign req.cacheable = (pc >= cache_base) && (pc < cache_limit); // window compare.

	assign redirect_now = pending | jump_wrong; // either a latched or a fresh redirect.
	assign drop = done & redirect_now; // the word for the old path is discarded.
	assign target = jump_wrong ? jump_addr : pending_addr; // the newest redirect wins.

	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
		end else if (done) begin
			busy <= 1'b0; // the cache is back in idle next cycle.
		end else if (req_valid) begin
			busy <= 1'b1; // the cache latched req this cycle.
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= reset_pc;
		end else if (drop) begin
			pc <= target; // restart on the redirected path.
		end else if (jump_wrong && !req_valid) begin
			pc <= jump_addr; // nothing in flight, so the target is taken at once.
		end else if (done && out_free) begin
			pc <= pc + 32'd4; // sequential step.
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (done) begin
			pending <= 1'b0; // consumed by the drop above.
		end else if (jump_wrong && req_valid) begin
			pending <= 1'b1; // wait for the fetch in flight to finish.
		end
	end

	always_ff @(posedge clock) begin
		if (jump_wrong) begin
			pending_addr <= jump_addr; // keep the latest target.
		end
	end

	// the cache holds its request until done, so neither the valid nor the pc may move early.
	a_req_held: assert property (@(posedge clock) disable iff (rst)
		(req_valid && !done) |=> (req_valid && $stable(req)));

endmodule

// ==== source/fetch_icache.sv ====
module fetch_icache import fetch_pkg::*; #(
	parameter int lines = 16
) (
	input logic clock,
	input logic rst,
	input fetch_req_t req,
	input logic req_valid,
	input refill_beat_t beat,
	input logic beat_valid,
	output logic miss_start,
	output logic [31:0] line_addr,
	output logic done,
	output logic [31:0] word
);

	typedef enum logic [1:0] {
		s_idle,
		s_lookup,
		s_fill,
		s_uncached
	} state_t;

	state_t state; // where the current request is.
	fetch_req_t cur; // request being served.
	fetch_addr_t cur_addr; // the same pc split into its fields.
	logic [tag_bits-1:0] tag_mem [lines]; // one tag per line.
	logic [xlen-1:0] data_mem [lines*line_words]; // all words, line after line.
	logic [lines-1:0] line_valid; // set for a line once its fill completes.
	logic [xlen-1:0] word_q; // the requested word caught during a fill.
	logic [xlen-1:0] rd_data; // array word addressed by cur.
	logic hit; // valid line with a matching tag.
	logic beat_match; // beat carries the word that cur asked for.
	logic fill_beat; // beat is written into the line.

	assign cur_addr = cur.pc;
	assign rd_data = data_mem[{cur_addr.index, cur_addr.offset}];
	assign hit = line_valid[cur_addr.index] && (tag_mem[cur_addr.index] == cur_addr.tag);
	assign fill_beat = (state == s_fill) && beat_valid && beat.cacheable;
	assign beat_match = beat_valid && ((state == s_uncached) || (beat.offset == cur_addr.offset));

	assign miss_start = (state == s_lookup) && !hit; // lasts one cycle since the state moves on.
	assign line_addr = {cur.pc[31:5], 5'b0}; // aligned to the 32-byte line.

	// a hit answers from the array and a fill or uncached read from the beat.
	assign done = ((state == s_lookup) && hit)
		|| (fill_beat && beat.last)
		|| ((state == s_uncached) && beat_valid && !beat.cacheable);

	always_comb begin
		if (state == s_lookup) begin
			word = rd_data;
		end else if (beat_match) begin
			word = beat.data; // forward the beat on the cycle it arrives.
		end else begin
			word = word_q;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= s_idle;
		end else begin
			case (state)
				s_idle: if (req_valid) state <= req.cacheable ? s_lookup : s_uncached;
				s_lookup: state <= hit ? s_idle : s_fill;
				s_fill: if (fill_beat && beat.last) state <= s_idle;
				s_uncached: if (beat_valid && !beat.cacheable) state <= s_idle;
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if ((state == s_idle) && req_valid) begin
			cur <= req; // held for the whole request.
		end
		if (beat_match) begin
			word_q <= beat.data; // keeps the word if the last beat is another one.
		end
	end

	always_ff @(posedge clock) begin
		if (fill_beat) begin
			data_mem[{cur_addr.index, beat.offset}] <= beat.data;
		end
		if (fill_beat && beat.last) begin
			tag_mem[cur_addr.index] <= cur_addr.tag;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			line_valid <= '0;
		end else if (fill_beat && beat.last) begin
			line_valid[cur_addr.index] <= 1'b1; // the line is whole now.
		end
	end

	initial begin
		a_lines: assert (lines == 2 ** index_bits); // the index field has to address every line.
	end

	// fill beats come only while the line is filling, so no second miss can start meanwhile.
	a_one_fill: assert property (@(posedge clock) disable iff (rst)
		(beat_valid && beat.cacheable) |-> (state == s_fill));

endmodule

// ==== source/fetch_bus.sv ====
module fetch_bus import fetch_pkg::*; (
	input logic clock,
	input logic rst,
	input logic miss_start,
	input logic [31:0] line_addr,
	input logic uncached_start,
	input logic [31:0] uncached_addr,
	output logic [31:0] araddr,
	output logic arvalid,
	input logic arready,
	output logic [1:0] arburst,
	output logic [3:0] arlen,
	input logic [31:0] rdata,
	input logic rlast,
	input logic rvalid,
	output logic rready,
	output refill_beat_t beat,
	output logic beat_valid
);

	localparam logic [1:0] burst_fixed = 2'b00;
	localparam logic [1:0] burst_incr = 2'b01;

	logic cached; // the transfer in progress fills a line.
	logic active; // address accepted, data still coming.
	logic [offset_bits-1:0] word_cnt; // word offset of the next beat.
	logic [3:0] beat_cnt; // beats seen in this transfer.
	logic take; // a data beat moves this cycle.

	assign rready = 1'b1; // the cache always has room for a beat.
	assign take = rvalid && rready;
	assign beat_valid = take;
	assign beat.data = rdata;
	assign beat.offset = word_cnt;
	assign beat.last = rlast;
	assign beat.cacheable = cached;

	always_ff @(posedge clock) begin
		if (rst) begin
			arvalid <= 1'b0;
			arburst <= burst_fixed;
			arlen <= 4'd0;
			cached <= 1'b0;
		end else if (miss_start) begin
			arvalid <= 1'b1;
			arburst <= burst_incr; // whole line, 8 beats.
			arlen <= 4'd7;
			cached <= 1'b1;
		end else if (uncached_start) begin
			arvalid <= 1'b1;
			arburst <= burst_fixed; // single word.
			arlen <= 4'd0;
			cached <= 1'b0;
		end else if (arvalid && arready) begin
			arvalid <= 1'b0; // held until the slave takes it.
		end
	end

	always_ff @(posedge clock) begin
		if (miss_start) begin
			araddr <= line_addr;
		end else if (uncached_start) begin
			araddr <= uncached_addr;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			active <= 1'b0;
		end else if (arvalid && arready) begin
			active <= 1'b1;
		end else if (take && rlast) begin
			active <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			word_cnt <= '0;
			beat_cnt <= '0;
		end else if (miss_start) begin
			word_cnt <= '0; // a burst starts at the line base.
			beat_cnt <= '0;
		end else if (uncached_start) begin
			word_cnt <= uncached_addr[4:2]; // the one word sits at its own offset.
			beat_cnt <= '0;
		end else if (take) begin
			word_cnt <= word_cnt + 1'b1;
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// the slave must end the burst exactly on the requested length.
	a_rlast_len: assert property (@(posedge clock) disable iff (rst)
		take |-> (rlast == (beat_cnt == arlen)));

	// data only after an address handshake.
	a_no_stray: assert property (@(posedge clock) disable iff (rst)
		rvalid |-> active);

endmodule

// ==== source/fetch_unit.sv ====
module fetch_unit import fetch_pkg::*; #(
	parameter logic [31:0] reset_pc = 32'h3000_0000,
	parameter logic [31:0] cache_base = 32'ha000_0000,
	parameter logic [31:0] cache_limit = 32'ha200_0000,
	parameter int lines = 16
) (
	input logic clock,
	input logic rst,
	output logic [31:0] araddr,
	output logic arvalid,
	input logic arready,
	output logic [1:0] arburst,
	output logic [3:0] arlen,
	input logic [31:0] rdata,
	input logic rlast,
	input logic rvalid,
	output logic rready,
	input logic jump_wrong,
	input logic [31:0] jump_addr,
	output fetch_out_t out,
	output logic out_valid,
	input logic out_ready
);

	fetch_req_t req; // pc stage to cache.
	logic req_valid;
	logic drop; // word of the finishing fetch belongs to a wrong path.
	logic done; // the word for req is on word.
	logic [31:0] word;
	logic out_free; // output register can load this cycle.
	logic miss_start;
	logic [31:0] line_addr;
	logic uncached_start; // one cycle pulse per uncached fetch.
	logic uncached_sent; // the uncached read for req is already out.
	refill_beat_t beat;
	logic beat_valid;

	assign out_free = !out_valid || out_ready;
	assign uncached_start = req_valid && !req.cacheable && !uncached_sent;

	always_ff @(posedge clock) begin
		if (rst) begin
			uncached_sent <= 1'b0;
		end else if (done) begin
			uncached_sent <= 1'b0; // the next request may issue its own read.
		end else if (uncached_start) begin
			uncached_sent <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (jump_wrong) begin
			out_valid <= 1'b0; // a held word on the old path is thrown away.
		end else if (done && !drop && out_free) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (done && !drop && out_free) begin
			out.pc <= req.pc;
			out.inst <= word;
		end
	end

	fetch_pc #(
		.reset_pc(reset_pc),
		.cache_base(cache_base),
		.cache_limit(cache_limit)
	) u_pc (
		.clock(clock), .rst(rst), .done(done), .out_free(out_free),
		.jump_wrong(jump_wrong), .jump_addr(jump_addr),
		.req(req), .req_valid(req_valid), .drop(drop)
	);

	fetch_icache #(
		.lines(lines)
	) u_icache (
		.clock(clock), .rst(rst), .req(req), .req_valid(req_valid),
		.beat(beat), .beat_valid(beat_valid), .miss_start(miss_start),
		.line_addr(line_addr), .done(done), .word(word)
	);

	fetch_bus u_bus (
		.clock(clock), .rst(rst), .miss_start(miss_start), .line_addr(line_addr),
		.uncached_start(uncached_start), .uncached_addr(req.pc),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.arburst(arburst), .arlen(arlen), .rdata(rdata), .rlast(rlast),
		.rvalid(rvalid), .rready(rready), .beat(beat), .beat_valid(beat_valid)
	);

endmodule

// ==== bench/fetch_clock.sv ====
module fetch_clock #(
	parameter int period = 4
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock; // half a period high, half low.
	end

endmodule

// ==== bench/fetch_mem.sv ====
module fetch_mem (
	input logic clock,
	input logic [31:0] araddr,
	input logic arvalid,
	output logic arready,
	input logic [1:0] arburst,
	input logic [3:0] arlen,
	output logic [31:0] rdata,
	output logic rlast,
	output logic rvalid,
	input logic rready
);

	logic [31:0] addr; // address of the beat being returned.
	logic incr; // the burst steps through the line.
	int len; // beats after the first one.
	int gap; // cycles that arready stays low.

	function automatic logic [31:0] mem_word(input logic [31:0] a);
		logic [31:0] x;
		x = a ^ 32'h5a5a_0000;
		return {x[24:0], x[31:25]}; // rotate left by 7.
	endfunction

	initial begin
		arready = 1'b0;
		rdata = '0;
		rlast = 1'b0;
		rvalid = 1'b0;
		forever begin
			@(negedge clock);
			if (arvalid) begin
				gap = $urandom % 4; // the master has to hold arvalid meanwhile.
				repeat (gap) @(negedge clock);
				addr = araddr;
				len = int'(arlen);
				incr = (arburst == 2'b01);
				arready = 1'b1; // taken at the next rising edge.
				@(negedge clock);
				arready = 1'b0;
				for (int i = 0; i <= len; i++) begin
					rdata = mem_word(addr);
					rlast = (i == len);
					rvalid = 1'b1;
					@(negedge clock);
					while (!rready) @(negedge clock);
					if (incr) addr = addr + 32'd4; // a fixed burst repeats its address.
				end
				rvalid = 1'b0;
				rlast = 1'b0;
			end
		end
	end

endmodule

// ==== bench/fetch_tb.sv ====
module fetch_tb import fetch_pkg::*; ();

	localparam int period = 4;
	localparam int num_tests = 6;
	localparam logic [31:0] reset_pc = 32'h3000_0000;
	localparam logic [31:0] cache_base = 32'ha000_0000;
	localparam logic [31:0] cache_limit = 32'ha200_0000;

	logic clock;
	logic rst;
	logic [31:0] araddr;
	logic arvalid;
	logic arready;
	logic [1:0] arburst;
	logic [3:0] arlen;
	logic [31:0] rdata;
	logic rlast;
	logic rvalid;
	logic rready;
	logic jump_wrong;
	logic [31:0] jump_addr;
	fetch_out_t out;
	logic out_valid;
	logic out_ready;

	int phase = 0; // group of behaviors now running.
	int accepted = 0; // words taken by the decode side.
	int single_reads = 0;
	int burst_reads = 0;
	int value_errors = 0;
	int other_errors = 0;
	logic [31:0] model_pc = reset_pc; // pc of the next word decode should see.
	logic held = 1'b0; // out was valid and not taken at the last edge.
	fetch_out_t held_out;
	logic ar_waiting = 1'b0; // an address was offered and not yet taken.
	logic [31:0] ar_addr_q;

	function automatic logic [31:0] expect_word(input logic [31:0] addr);
		logic [31:0] x;
		x = addr ^ 32'h5a5a_0000;
		return {x[24:0], x[31:25]}; // memory holds the address xor a mask rotated left by 7.
	endfunction

	function automatic logic in_window(input logic [31:0] addr);
		return (addr >= cache_base) && (addr < cache_limit);
	endfunction

	function automatic logic [31:0] pick_target();
		if ($urandom % 2) return cache_base + (($urandom % 512) << 2); // a 2 KiB span makes lines collide.
		return reset_pc + (($urandom % 256) << 2);
	endfunction

	fetch_clock #(.period(period)) u_clock (.clock(clock));

	fetch_mem u_mem (
		.clock(clock), .araddr(araddr), .arvalid(arvalid), .arready(arready),
		.arburst(arburst), .arlen(arlen), .rdata(rdata), .rlast(rlast),
		.rvalid(rvalid), .rready(rready)
	);

	fetch_unit #(
		.reset_pc(reset_pc), .cache_base(cache_base), .cache_limit(cache_limit), .lines(16)
	) UUT (
		.clock(clock), .rst(rst), .araddr(araddr), .arvalid(arvalid), .arready(arready),
		.arburst(arburst), .arlen(arlen), .rdata(rdata), .rlast(rlast), .rvalid(rvalid),
		.rready(rready), .jump_wrong(jump_wrong), .jump_addr(jump_addr), .out(out),
		.out_valid(out_valid), .out_ready(out_ready)
	);

	always @(posedge clock) begin
		if (!rst) begin
			if (held) assert (out_valid && (out == held_out)) else begin
				$display("[ERROR] out %h expected %h while held", out, held_out);
				value_errors++;
			end
			if (out_valid && out_ready) begin
				assert (out.pc == model_pc) else begin
					$display("[ERROR] out.pc %h expected %h", out.pc, model_pc);
					value_errors++;
				end
				assert (out.inst == expect_word(model_pc)) else begin
					$display("[ERROR] out.inst %h expected %h", out.inst, expect_word(model_pc));
					value_errors++;
				end
				model_pc = model_pc + 32'd4;
				accepted++;
			end
			if (jump_wrong) model_pc = jump_addr; // the old path is dead from here on.
			held = out_valid && !out_ready && !jump_wrong;
			held_out = out;
			assert (rready) else begin
				$display("[ERROR] rready %h expected 1", rready);
				value_errors++;
			end
			if (ar_waiting) assert (arvalid && (araddr == ar_addr_q)) else begin
				$display("[ERROR] araddr %h arvalid %h expected %h and 1", araddr, arvalid, ar_addr_q);
				value_errors++;
			end
			if (arvalid && arready && in_window(araddr)) begin
				burst_reads++;
				assert ((araddr[4:0] == 5'd0) && (arlen == 4'd7) && (arburst == 2'b01)) else begin
					$display("[ERROR] burst araddr %h arlen %h arburst %h", araddr, arlen, arburst);
					value_errors++;
				end
			end else if (arvalid && arready) begin
				single_reads++;
				assert ((arlen == 4'd0) && (arburst == 2'b00) && (phase != 1 || araddr == model_pc))
				else begin
					$display("[ERROR] single araddr %h arlen %h arburst %h pc %h", araddr, arlen,
						arburst, model_pc);
					value_errors++;
				end
			end
			ar_waiting = arvalid && !arready;
			ar_addr_q = araddr;
		end
	end

	task automatic stream_words(input int n, input bit random_ready);
		int target;
		target = accepted + n;
		out_ready = random_ready ? (($urandom % 2) == 1) : 1'b1;
		while (accepted < target) begin
			@(negedge clock);
			if (accepted >= target) out_ready = 1'b0; // stop right after the last one.
			else out_ready = random_ready ? (($urandom % 2) == 1) : 1'b1;
		end
	endtask

	task automatic settle();
		out_ready = 1'b0;
		while (!out_valid) @(negedge clock); // the fetch in flight lands on out and stalls.
	endtask

	task automatic redirect(input logic [31:0] target);
		out_ready = 1'b0; // nothing is taken on the strobe cycle.
		jump_wrong = 1'b1;
		jump_addr = target;
		@(negedge clock);
		jump_wrong = 1'b0;
	endtask

	task automatic check_reads(input int singles, input int bursts);
		assert ((single_reads == singles) && (burst_reads == bursts)) else begin
			$display("phase %0d saw %0d single and %0d burst reads where %0d and %0d belong",
				phase, single_reads, burst_reads, singles, bursts);
			other_errors++;
		end
	endtask

	task automatic finish_run(input bit timed_out);
		$display("errors: %0d value, %0d other, %0d words checked", value_errors, other_errors,
			accepted);
		if (!timed_out && value_errors == 0 && other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	endtask

	initial begin
		#(num_tests * 2000 * period);
		$display("timeout: the fetch unit stopped delivering words");
		other_errors++;
		finish_run(1'b1);
	end

	initial begin
		int gap_cycles;
		void'($urandom(13));
		rst = 1'b1;
		out_ready = 1'b0;
		jump_wrong = 1'b0;
		jump_addr = '0;
		repeat (16) @(negedge clock);
		rst = 1'b0;
		phase = 1; // uncached stream with one single read per word plus the held one.
		stream_words(16, 1'b0);
		settle();
		check_reads(17, 0);
		phase = 2; // four lines plus the held word's line take one burst each.
		redirect(cache_base + 32'h100);
		stream_words(32, 1'b0);
		settle();
		check_reads(17, 5);
		phase = 3; // the same lines again hit every time.
		redirect(cache_base + 32'h100);
		stream_words(32, 1'b0);
		settle();
		check_reads(17, 5);
		phase = 4;
		redirect(cache_base + 32'h3e0);
		stream_words(48, 1'b1);
		redirect(reset_pc + 32'h200);
		stream_words(16, 1'b1);
		phase = 5; // redirects land during misses, uncached reads and held words.
		for (int i = 0; i < 40; i++) begin
			if (i % 4 == 0) settle();
			redirect(pick_target());
			gap_cycles = $urandom % 24;
			repeat (gap_cycles) begin
				@(negedge clock);
				out_ready = (($urandom % 2) == 1);
			end
		end
		stream_words(12, 1'b1);
		phase = 6; // fresh lines with the slave's arready delay.
		redirect(cache_base + 32'h800);
		stream_words(24, 1'b0);
		finish_run(1'b0);
	end

endmodule

// ==== list.f ====
source/fetch_pkg.sv
source/fetch_pc.sv
source/fetch_icache.sv
source/fetch_bus.sv
source/fetch_unit.sv
bench/fetch_clock.sv
bench/fetch_mem.sv
bench/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= fetch_tb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
